/* gfx_macros.svh */
`ifndef GFX_MACROS_SVH
`define GFX_MACROS_SVH

// Screen geometry.
`define GFX_COORD_BITS   6
`define GFX_SCREEN_SIZE  64

// Tile side and lanes per block.
`define GFX_RASTER_SIZE  4
`define GFX_FINE_LANES   16

// Stage depths.
`define GFX_SETUP_STAGES 3
`define GFX_FINE_STAGES  2

// Signed edge arithmetic.
`define GFX_EDGE_BITS    16

`endif

/* gfx_pkg.sv */
`include "gfx_macros.svh"

package gfx_pkg;

	typedef logic [`GFX_COORD_BITS - 1:0] coord_t;

	// Index 1 holds x, index 0 holds y.
	typedef coord_t [1:0] raster_xy;
	typedef raster_xy frag_xy;

	typedef logic signed [`GFX_EDGE_BITS - 1:0] edge_t;

	// Edge 0 is a to b, edge 1 is b to c, edge 2 is c to a.
	typedef edge_t [2:0] fixed_tri;

	typedef logic [$clog2(`GFX_SCREEN_SIZE / `GFX_RASTER_SIZE) - 1:0] coarse_dim;

	// Lane index is y * tile side + x.
	typedef logic [`GFX_FINE_LANES - 1:0] paint_lanes;
	typedef frag_xy [`GFX_FINE_LANES - 1:0] frag_xy_lanes;

	typedef enum logic [1:0] {
		IDLE,
		WALK,
		LAST
	} coarse_state_t;

endpackage

/* gfx_pipeline_flow.sv */
module gfx_pipeline_flow #(
	parameter int STAGES = 1
)
(
	input  logic clk,
	input  logic rst_n,

	input  logic in_valid,
	output logic in_ready,

	output logic out_valid,
	input  logic out_ready,

	output logic stall
);

	logic [STAGES - 1:0] valid;

	assign out_valid = valid[STAGES - 1];

	// Whole chain freezes while the tail is blocked.
	assign stall = out_valid && !out_ready;
	assign in_ready = !stall;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid <= '0;
		end else if (!stall) begin
			valid[0] <= in_valid;
			for (int i = 1; i < STAGES; i++) begin
				valid[i] <= valid[i - 1];
			end
		end
	end

endmodule

/* gfx_skid_buf.sv */
module gfx_skid_buf #(
	parameter int WIDTH = 1
)
(
	input  logic               clk,
	input  logic               rst_n,

	input  logic               stall,
	input  logic [WIDTH - 1:0] in,
	output logic [WIDTH - 1:0] out
);

	logic               held;
	logic [WIDTH - 1:0] held_data;

	always_ff @(posedge clk) begin
		if (!rst_n)
			held <= 1'b0;
		else
			held <= stall;
	end

	always_ff @(posedge clk) begin
		if (stall && !held)
			held_data <= in; // First stalled cycle.
	end

	assign out = held ? held_data : in;

endmodule

/* gfx_setup.sv */
`include "gfx_macros.svh"

module gfx_setup
	import gfx_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      stall,

	input  raster_xy  vertex_a,
	input  raster_xy  vertex_b,
	input  raster_xy  vertex_c,

	output fixed_tri  step_x,
	output fixed_tri  step_y,
	output fixed_tri  edge_refs,
	output raster_xy  pos_ref,
	output coarse_dim span_x,
	output coarse_dim span_y,
	output logic      empty
);

	function automatic edge_t diff(coord_t p, coord_t q);
		return edge_t'(p) - edge_t'(q);
	endfunction

	function automatic coord_t min3(coord_t p, coord_t q, coord_t r);
		coord_t m;
		m = p < q ? p : q;
		return m < r ? m : r;
	endfunction

	function automatic coord_t max3(coord_t p, coord_t q, coord_t r);
		coord_t m;
		m = p > q ? p : q;
		return m > r ? m : r;
	endfunction

	localparam coord_t TILE_MASK = coord_t'(`GFX_RASTER_SIZE - 1);

	edge_t    area;
	raster_xy s1_v[3], s2_v[3];
	raster_xy s2_lo, s2_hi;
	fixed_tri s2_step_x, s2_step_y, st_x, st_y, refs;
	logic     s1_empty, s2_empty;

	// Doubled signed area, positive for the kept winding.
	always_comb begin
		area = diff(vertex_b[1], vertex_a[1]) * diff(vertex_c[0], vertex_a[0])
		     - diff(vertex_b[0], vertex_a[0]) * diff(vertex_c[1], vertex_a[1]);
	end

	always_comb begin
		for (int i = 0; i < 3; i++) begin
			st_x[i] = diff(s1_v[i][0], s1_v[(i + 1) % 3][0]);
			st_y[i] = diff(s1_v[(i + 1) % 3][1], s1_v[i][1]);
			refs[i] = s2_step_x[i] * diff(s2_lo[1], s2_v[i][1])
			        + s2_step_y[i] * diff(s2_lo[0], s2_v[i][0]);
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			s1_v[0] <= vertex_a;
			s1_v[1] <= area < 0 ? vertex_c : vertex_b; // Swap b and c.
			s1_v[2] <= area < 0 ? vertex_b : vertex_c;

			s2_v <= s1_v;
			s2_step_x <= st_x;
			s2_step_y <= st_y;
			s2_lo[1] <= min3(s1_v[0][1], s1_v[1][1], s1_v[2][1]) & ~TILE_MASK;
			s2_lo[0] <= min3(s1_v[0][0], s1_v[1][0], s1_v[2][0]) & ~TILE_MASK;
			s2_hi[1] <= max3(s1_v[0][1], s1_v[1][1], s1_v[2][1]) | TILE_MASK;
			s2_hi[0] <= max3(s1_v[0][0], s1_v[1][0], s1_v[2][0]) | TILE_MASK;

			step_x <= s2_step_x;
			step_y <= s2_step_y;
			edge_refs <= refs;
			pos_ref <= s2_lo;
			span_x <= coarse_dim'((s2_hi[1] - s2_lo[1]) / `GFX_RASTER_SIZE);
			span_y <= coarse_dim'((s2_hi[0] - s2_lo[0]) / `GFX_RASTER_SIZE);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s1_empty <= 1'b0;
			s2_empty <= 1'b0;
			empty <= 1'b0;
		end else if (!stall) begin
			s1_empty <= area == 0;
			s2_empty <= s1_empty;
			empty <= s2_empty;
		end
	end

endmodule

/* gfx_coarse.sv */
`include "gfx_macros.svh"

module gfx_coarse
	import gfx_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,

	input  logic      in_valid,
	output logic      in_ready,
	output logic      out_valid,
	input  logic      out_ready,

	input  fixed_tri  step_x,
	input  fixed_tri  step_y,
	input  fixed_tri  edge_refs,
	input  raster_xy  pos_ref,
	input  coarse_dim span_x,
	input  coarse_dim span_y,
	input  logic      empty,

	output raster_xy  pos,
	output fixed_tri  corners,
	output fixed_tri  step_x_out,
	output fixed_tri  step_y_out
);

	coarse_state_t state;
	coarse_dim     tile_x, tile_y, next_x, next_y, last_x, last_y;
	fixed_tri      sx_q, sy_q, row_q, corner_q;
	fixed_tri      tile_dx, tile_dy, reach, next_row, next_col;
	raster_xy      org_q;
	logic          hit, advance, row_end;

	// Largest value over the tile's four corners, per edge.
	always_comb begin
		hit = 1'b1;
		for (int i = 0; i < 3; i++) begin
			tile_dx[i] = sx_q[i] * edge_t'(`GFX_RASTER_SIZE);
			tile_dy[i] = sy_q[i] * edge_t'(`GFX_RASTER_SIZE);
			next_row[i] = row_q[i] + tile_dy[i];
			next_col[i] = corner_q[i] + tile_dx[i];
			reach[i] = corner_q[i];
			if (sx_q[i] > 0)
				reach[i] = reach[i] + tile_dx[i] - sx_q[i];
			if (sy_q[i] > 0)
				reach[i] = reach[i] + tile_dy[i] - sy_q[i];
			hit = hit && reach[i] >= 0;
		end
	end

	assign row_end = tile_x == last_x;
	assign next_x = row_end ? '0 : tile_x + 1'b1;
	assign next_y = row_end ? tile_y + 1'b1 : tile_y;

	assign in_ready = state == IDLE;
	assign out_valid = state != IDLE && hit;
	assign advance = state != IDLE && (!hit || out_ready); // Rejects take one cycle.

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= IDLE;
			tile_x <= '0;
			tile_y <= '0;
		end else begin
			case (state)
				IDLE: if (in_valid) begin
					tile_x <= '0;
					tile_y <= '0;
					if (empty)
						state <= IDLE;
					else if (span_x == '0 && span_y == '0)
						state <= LAST;
					else
						state <= WALK;
				end
				WALK: if (advance) begin
					tile_x <= next_x;
					tile_y <= next_y;
					if (next_x == last_x && next_y == last_y)
						state <= LAST;
				end
				LAST: if (advance) state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			sx_q <= step_x;
			sy_q <= step_y;
			row_q <= edge_refs;
			corner_q <= edge_refs;
			org_q <= pos_ref;
			last_x <= span_x;
			last_y <= span_y;
		end else if (advance) begin
			if (row_end) begin
				row_q <= next_row;
				corner_q <= next_row;
			end else begin
				corner_q <= next_col;
			end
		end
	end

	assign pos[1] = org_q[1] + coord_t'(tile_x * `GFX_RASTER_SIZE);
	assign pos[0] = org_q[0] + coord_t'(tile_y * `GFX_RASTER_SIZE);
	assign corners = corner_q;
	assign step_x_out = sx_q;
	assign step_y_out = sy_q;

endmodule

/* gfx_fine.sv */
module gfx_fine
	import gfx_pkg::*;
#(
	parameter int X = 0,
	parameter int Y = 0
)
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     stall,

	input  raster_xy pos,
	input  fixed_tri corners,
	input  fixed_tri step_x,
	input  fixed_tri step_y,

	output logic     paint,
	output frag_xy   fragment
);

	fixed_tri sum, sum_q;
	frag_xy   frag_q;

	always_comb begin
		for (int i = 0; i < 3; i++)
			sum[i] = corners[i] + edge_t'(X) * step_x[i] + edge_t'(Y) * step_y[i];
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			sum_q <= sum;
			frag_q[1] <= pos[1] + coord_t'(X);
			frag_q[0] <= pos[0] + coord_t'(Y);
			fragment <= frag_q;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			paint <= 1'b0;
		else if (!stall)
			paint <= sum_q[0] >= 0 && sum_q[1] >= 0 && sum_q[2] >= 0; // Inside all edges.
	end

endmodule

/* gfx_raster.sv */
`include "gfx_macros.svh"

module gfx_raster
	import gfx_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,

	input  raster_xy     vertex_a,
	input  raster_xy     vertex_b,
	input  raster_xy     vertex_c,
	input  logic         in_valid,
	output logic         in_ready,

	output frag_xy_lanes fragments,
	input  logic         out_ready,
	output paint_lanes   out_valid
);

	logic       setup_stall, setup_valid;
	logic       coarse_ready, coarse_valid;
	logic       fine_ready, fine_stall, fine_valid;

	fixed_tri   step_x, step_y, edge_refs;
	raster_xy   pos_ref;
	coarse_dim  span_x, span_y;
	logic       empty;

	raster_xy   coarse_pos;
	fixed_tri   coarse_corners, fine_step_x, fine_step_y;

	paint_lanes paint_ij, skid_paint_ij;
	frag_xy     fragment_ij[`GFX_RASTER_SIZE][`GFX_RASTER_SIZE];

	gfx_pipeline_flow #(.STAGES(`GFX_SETUP_STAGES)) setup_flow (
		.stall(setup_stall),
		.out_ready(coarse_ready),
		.out_valid(setup_valid),
		.*
	);

	gfx_setup setup (
		.stall(setup_stall),
		.*
	);

	gfx_coarse coarse (
		.in_valid(setup_valid),
		.in_ready(coarse_ready),
		.out_valid(coarse_valid),
		.out_ready(fine_ready),
		.pos(coarse_pos),
		.corners(coarse_corners),
		.step_x_out(fine_step_x),
		.step_y_out(fine_step_y),
		.*
	);

	// Blocks with nothing to paint drain without waiting.
	gfx_pipeline_flow #(.STAGES(`GFX_FINE_STAGES)) fine_flow (
		.clk,
		.rst_n,
		.in_valid(coarse_valid),
		.in_ready(fine_ready),
		.out_valid(fine_valid),
		.out_ready(out_ready || !(|skid_paint_ij)),
		.stall(fine_stall)
	);

	gfx_skid_buf #(.WIDTH(`GFX_FINE_LANES)) skid_paint (
		.stall(fine_stall),
		.in(paint_ij),
		.out(skid_paint_ij),
		.*
	);

	assign out_valid = skid_paint_ij & {`GFX_FINE_LANES{fine_valid}};

	genvar i, j;
	generate
		for (i = 0; i < `GFX_RASTER_SIZE; i++) begin : fine_x
			for (j = 0; j < `GFX_RASTER_SIZE; j++) begin : fine_y
				gfx_fine #(.X(i), .Y(j)) fine (
					.clk,
					.rst_n,
					.stall(fine_stall),
					.pos(coarse_pos),
					.corners(coarse_corners),
					.step_x(fine_step_x),
					.step_y(fine_step_y),
					.paint(paint_ij[j * `GFX_RASTER_SIZE + i]),
					.fragment(fragment_ij[i][j])
				);

				gfx_skid_buf #(.WIDTH($bits(frag_xy))) skid_fragment (
					.stall(fine_stall),
					.in(fragment_ij[i][j]),
					.out(fragments[j * `GFX_RASTER_SIZE + i]),
					.*
				);
			end
		end
	endgenerate

endmodule

/* gfx_raster_model.svh */
`ifndef GFX_RASTER_MODEL_SVH
`define GFX_RASTER_MODEL_SVH

// Expected blocks in output order, tile origin and paint mask.
raster_xy   exp_pos[$];
paint_lanes exp_mask[$];

// Cross product of (q - p) and (r - p).
function automatic int edge_value(int px, int py, int qx, int qy, int rx, int ry);
	return (qx - px) * (ry - py) - (qy - py) * (rx - px);
endfunction

function automatic int align_down(int v);
	return v - v % `GFX_RASTER_SIZE;
endfunction

function automatic int smallest(int p, int q, int r);
	int m;
	m = p;
	if (q < m)
		m = q;
	if (r < m)
		m = r;
	return m;
endfunction

function automatic int largest(int p, int q, int r);
	int m;
	m = p;
	if (q > m)
		m = q;
	if (r > m)
		m = r;
	return m;
endfunction

task automatic expect_blocks(input raster_xy a, input raster_xy b, input raster_xy c);
	int         ax, ay, bx, by, cx, cy, t, area;
	int         lo_x, lo_y, hi_x, hi_y, px, py;
	paint_lanes mask;
	ax = a[1];
	ay = a[0];
	bx = b[1];
	by = b[0];
	cx = c[1];
	cy = c[0];
	area = edge_value(ax, ay, bx, by, cx, cy);
	if (area < 0) begin
		t = bx; // Make the winding counter-clockwise.
		bx = cx;
		cx = t;
		t = by;
		by = cy;
		cy = t;
	end
	lo_x = align_down(smallest(ax, bx, cx));
	lo_y = align_down(smallest(ay, by, cy));
	hi_x = align_down(largest(ax, bx, cx));
	hi_y = align_down(largest(ay, by, cy));
	if (area != 0) begin
		for (int ty = lo_y; ty <= hi_y; ty += `GFX_RASTER_SIZE) begin
			for (int tx = lo_x; tx <= hi_x; tx += `GFX_RASTER_SIZE) begin
				mask = '0;
				for (int lane = 0; lane < `GFX_FINE_LANES; lane++) begin
					px = tx + lane % `GFX_RASTER_SIZE;
					py = ty + lane / `GFX_RASTER_SIZE;
					if (edge_value(ax, ay, bx, by, px, py) >= 0 &&
					    edge_value(bx, by, cx, cy, px, py) >= 0 &&
					    edge_value(cx, cy, ax, ay, px, py) >= 0)
						mask[lane] = 1'b1;
				end
				if (mask != '0) begin
					exp_pos.push_back({coord_t'(tx), coord_t'(ty)});
					exp_mask.push_back(mask);
				end
			end
		end
	end
endtask

`endif

/* gfx_raster_tb.sv */
`include "gfx_macros.svh"

module gfx_raster_tb
	import gfx_pkg::*;
();

	localparam int          PERIOD = 4;
	localparam int          RESET_CYCLES = 16;
	localparam logic [31:0] SEED = 32'd21184;
	localparam int          RANDOM_TRIS = 300;
	localparam int          TRI_COUNT = 7 + 2 * RANDOM_TRIS;
	localparam int          WATCHDOG_TIME =
		(TRI_COUNT * (256 + 16) * 4 + RESET_CYCLES) * PERIOD;

	logic         clk;
	logic         rst_n;
	raster_xy     vertex_a;
	raster_xy     vertex_b;
	raster_xy     vertex_c;
	logic         in_valid;
	logic         in_ready;
	frag_xy_lanes fragments;
	logic         out_ready;
	paint_lanes   out_valid;

	logic [31:0]  vert_state;
	logic [31:0]  ready_state;
	logic         random_ready;
	logic         hold_valid;
	paint_lanes   held_mask;
	frag_xy_lanes held_frags;

	`include "gfx_raster_model.svh"

	gfx_raster DUT (.*);

	always #(PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic raster_xy make_xy(input int x, input int y);
		return {coord_t'(x), coord_t'(y)};
	endfunction

	task automatic stop_on_failure(input string reason);
		$display("%s", reason);
		$display("** FAIL **");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
	                           input string what);
		if (actual !== expected) begin
			$display("Error at time %0t: %s is %0h, expected %0h",
			         $time, what, actual, expected);
			stop_on_failure("DUT output differs from the model");
		end
	endtask

	// Called at posedge plus one, returns there after the handshake.
	task automatic send_triangle(input raster_xy a, input raster_xy b, input raster_xy c);
		logic taken;
		expect_blocks(a, b, c);
		vertex_a = a;
		vertex_b = b;
		vertex_c = c;
		in_valid = 1'b1;
		taken = 1'b0;
		while (!taken) begin
			@(negedge clk);
			taken = in_ready;
			@(posedge clk);
			#1;
		end
		in_valid = 1'b0;
	endtask

	task automatic send_random_triangle();
		raster_xy v[3];
		for (int k = 0; k < 3; k++) begin
			vert_state = xorshift32(vert_state);
			v[k] = {vert_state[21:16], vert_state[5:0]};
			if (k > 0 && vert_state[30])
				v[k] = {v[0][1] + coord_t'(vert_state[11:8]),
				        v[0][0] + coord_t'(vert_state[27:24])}; // Small triangle.
		end
		send_triangle(v[0], v[1], v[2]);
	endtask

	task automatic wait_drained();
		while (exp_pos.size() != 0)
			@(posedge clk);
		repeat (8) @(posedge clk);
		#1;
	endtask

	task automatic take_block();
		raster_xy   tile;
		paint_lanes mask;
		frag_xy     want;
		if (exp_pos.size() == 0) begin
			stop_on_failure("DUT presented a block that the model does not expect");
		end else begin
			tile = exp_pos.pop_front();
			mask = exp_mask.pop_front();
			check_value(out_valid, mask,
			            $sformatf("paint mask of tile (%0d, %0d)", tile[1], tile[0]));
			for (int lane = 0; lane < `GFX_FINE_LANES; lane++) begin
				want[1] = tile[1] + coord_t'(lane % `GFX_RASTER_SIZE);
				want[0] = tile[0] + coord_t'(lane / `GFX_RASTER_SIZE);
				if (mask[lane])
					check_value(fragments[lane], want, $sformatf("fragment of lane %0d", lane));
			end
		end
	endtask

	// Outputs settle well before the falling edge.
	always @(negedge clk) begin
		if (rst_n) begin
			if (hold_valid) begin
				check_value(out_valid, held_mask, "mask of a held block");
				for (int lane = 0; lane < `GFX_FINE_LANES; lane++) begin
					if (held_mask[lane])
						check_value(fragments[lane], held_frags[lane],
						            $sformatf("held fragment of lane %0d", lane));
				end
			end
			hold_valid = 1'b0;
			if (out_valid != '0 && out_ready) begin
				take_block();
			end else if (out_valid != '0) begin
				hold_valid = 1'b1;
				held_mask = out_valid;
				held_frags = fragments;
			end
		end
	end

	always @(posedge clk) begin
		if (random_ready) begin
			ready_state = xorshift32(ready_state);
			#1;
			out_ready = ready_state[7:0] < 8'd150; // Roughly 60 percent ready.
		end else begin
			#1;
			out_ready = 1'b1;
		end
	end

	initial begin
		#(WATCHDOG_TIME);
		stop_on_failure("Timeout, the DUT stopped accepting triangles or producing blocks");
	end

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		in_valid = 1'b0;
		vertex_a = '0;
		vertex_b = '0;
		vertex_c = '0;
		out_ready = 1'b1;
		random_ready = 1'b0;
		hold_valid = 1'b0;
		held_mask = '0;
		held_frags = '0;
		vert_state = SEED;
		ready_state = SEED;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;

		@(negedge clk);
		check_value(out_valid, '0, "out_valid after reset");
		check_value(in_ready, 1'b1, "in_ready after reset");
		@(posedge clk);
		#1;

		// Same triangle in both windings.
		send_triangle(make_xy(5, 3), make_xy(40, 10), make_xy(20, 45));
		wait_drained();
		send_triangle(make_xy(5, 3), make_xy(20, 45), make_xy(40, 10));
		wait_drained();

		// Collinear and repeated vertices, then a normal triangle.
		send_triangle(make_xy(2, 2), make_xy(20, 20), make_xy(50, 50));
		send_triangle(make_xy(9, 30), make_xy(9, 30), make_xy(33, 12));
		send_triangle(make_xy(30, 8), make_xy(12, 40), make_xy(60, 50));
		wait_drained();

		// Two halves of the screen.
		send_triangle(make_xy(0, 0), make_xy(63, 0), make_xy(0, 63));
		send_triangle(make_xy(63, 63), make_xy(1, 63), make_xy(63, 1));
		wait_drained();

		for (int n = 0; n < RANDOM_TRIS; n++)
			send_random_triangle();
		wait_drained();

		// Same stream again under back-pressure.
		vert_state = SEED;
		random_ready = 1'b1;
		for (int n = 0; n < RANDOM_TRIS; n++)
			send_random_triangle();
		wait_drained();
		random_ready = 1'b0;

		repeat (20) @(posedge clk);
		@(negedge clk);
		check_value(out_valid, '0, "out_valid at the end");
		check_value(in_ready, 1'b1, "in_ready at the end");
		$display("** PASS **");
		$finish;
	end

endmodule

/* build.f */
+incdir+.
gfx_pkg.sv
gfx_pipeline_flow.sv
gfx_skid_buf.sv
gfx_setup.sv
gfx_coarse.sv
gfx_fine.sv
gfx_raster.sv
gfx_raster_tb.sv

/* Bender.yml */
package:
  name: gfx_raster

export_include_dirs:
  - .

sources:
  - gfx_pkg.sv
  - gfx_pipeline_flow.sv
  - gfx_skid_buf.sv
  - gfx_setup.sv
  - gfx_coarse.sv
  - gfx_fine.sv
  - gfx_raster.sv
  - target: test
    files:
      - gfx_raster_tb.sv
